//--- logic/ack_done_generator.sv
`include "ack_macros.svh"

module ack_done_generator
    import ack_msg_pkg::*;
(
    // ethclk side
    input  logic       aclk,
    input  logic       arst_n,
    input  ack_word_t  s_ack_tdata,
    input  logic       s_ack_tvalid,
    output logic       s_ack_tready,
    input  ack_word_t  s_nack_tdata,
    input  logic       s_nack_tvalid,
    output logic       s_nack_tready,
    // memory clock side
    input  logic       memclk,
    output nack_word_t m_nack_tdata,
    output logic       m_nack_tvalid,
    input  logic       m_nack_tready,
    output logic       allow,
    output done_addr_t m_hdraddr_tdata,
    output logic       m_hdraddr_tvalid,
    input  logic       m_hdraddr_tready,
    output done_addr_t m_t0addr_tdata,
    output logic       m_t0addr_tvalid,
    input  logic       m_t0addr_tready,
    output done_addr_t m_t1addr_tdata,
    output logic       m_t1addr_tvalid,
    input  logic       m_t1addr_tready,
    output done_addr_t m_t2addr_tdata,
    output logic       m_t2addr_tvalid,
    input  logic       m_t2addr_tready,
    output done_addr_t m_t3addr_tdata,
    output logic       m_t3addr_tvalid,
    input  logic       m_t3addr_tready
);

    nack_word_t nack_din;
    logic       nack_full;

    done_addr_t ack_din;
    logic       ack_full;
    done_addr_t ack_dout;
    logic       ack_valid;
    logic       ack_rd;

    logic       allow_a;

    done_addr_t                bc_addr;
    logic [`N_CONSUMERS-1:0]   bc_valid;
    logic [`N_CONSUMERS-1:0]   bc_ready;

    // nack keeps the flag bit and the low field, bits 45 to 43 are constant
    assign nack_din      = {s_nack_tdata[NACK_FLAG_BIT], s_nack_tdata[`NACK_W-2:0]};
    assign s_nack_tready = !nack_full;

    async_fifo #(
        .WIDTH (`NACK_W),
        .DEPTH (`NACK_FIFO_DEPTH)
    ) u_nackfifo (
        .wr_clk   (aclk),
        .rd_clk   (memclk),
        .arst_n   (arst_n),
        .wr_data  (nack_din),
        .wr_en    (s_nack_tvalid && s_nack_tready),
        .full     (nack_full),
        .rd_data  (m_nack_tdata),
        .rd_valid (m_nack_tvalid),
        .rd_en    (m_nack_tready)
    );

    // only the done address of an ack is stored
    assign ack_din      = s_ack_tdata[ACK_ADDR_LSB +: `DONE_ADDR_W];
    assign s_ack_tready = !ack_full;

    async_fifo #(
        .WIDTH (`DONE_ADDR_W),
        .DEPTH (`ACK_FIFO_DEPTH)
    ) u_ackfifo (
        .wr_clk   (aclk),
        .rd_clk   (memclk),
        .arst_n   (arst_n),
        .wr_data  (ack_din),
        .wr_en    (s_ack_tvalid && s_ack_tready),
        .full     (ack_full),
        .rd_data  (ack_dout),
        .rd_valid (ack_valid),
        .rd_en    (ack_rd)
    );

    doneaddr_broadcast u_broadcast (
        .clk       (memclk),
        .arst_n    (arst_n),
        .in_addr   (ack_dout),
        .in_valid  (ack_valid),
        .in_rd     (ack_rd),
        .out_addr  (bc_addr),
        .out_valid (bc_valid),
        .out_ready (bc_ready)
    );

    // header stream on the top bit, transmit streams below it
    assign bc_ready = {m_hdraddr_tready, m_t0addr_tready, m_t1addr_tready,
                       m_t2addr_tready, m_t3addr_tready};

    assign m_hdraddr_tvalid = bc_valid[4];
    assign m_t0addr_tvalid  = bc_valid[3];
    assign m_t1addr_tvalid  = bc_valid[2];
    assign m_t2addr_tvalid  = bc_valid[1];
    assign m_t3addr_tvalid  = bc_valid[0];

    assign m_hdraddr_tdata = bc_addr;
    assign m_t0addr_tdata  = bc_addr;
    assign m_t1addr_tdata  = bc_addr;
    assign m_t2addr_tdata  = bc_addr;
    assign m_t3addr_tdata  = bc_addr;

    // one pulse per accepted ack that asks for it
    assign allow_a = s_ack_tvalid && s_ack_tready && s_ack_tdata[ACK_ALLOW_BIT];

    flag_sync u_allow_sync (
        .clk_a  (aclk),
        .clk_b  (memclk),
        .arst_n (arst_n),
        .flag_a (allow_a),
        .flag_b (allow)
    );

endmodule

//--- logic/ack_macros.svh
`ifndef ACK_MACROS_SVH
`define ACK_MACROS_SVH

// raw ack and nack words as they arrive from ethclk
`define ACK_IN_W 48
// nack word once the constant bits are peeled off
`define NACK_W 44
`define DONE_ADDR_W 12

// the ack FIFO must hold every outstanding done address
`define ACK_FIFO_DEPTH 4096
`define NACK_FIFO_DEPTH 512

`define SYNC_STAGES 2
`define N_CONSUMERS 5

`endif

//--- logic/ack_msg_pkg.sv
`include "ack_macros.svh"

package ack_msg_pkg;

    // raw word from either the ack or the nack stream
    typedef logic [`ACK_IN_W-1:0] ack_word_t;

    // kept nack bits, flag bit on top of the low field
    typedef logic [`NACK_W-1:0] nack_word_t;

    // address handed back to the header and transmit streams
    typedef logic [`DONE_ADDR_W-1:0] done_addr_t;

    // ack word, bit 47 asks for an allow pulse
    localparam int ACK_ALLOW_BIT = 47;

    // ack word, done address starts here and runs DONE_ADDR_W bits up
    localparam int ACK_ADDR_LSB = 20;

    // nack word, the only bit kept from the top nibble
    localparam int NACK_FLAG_BIT = 46;

    // bits 45 to 43 of a nack are constant and dropped
    // bits 42 down to 0 are kept as they are

endpackage

//--- logic/async_fifo.sv
`include "ack_macros.svh"

module async_fifo
    import cdc_pkg::*;
#(
    parameter int WIDTH = 12,
    parameter int DEPTH = 4096
) (
    input  logic             wr_clk,
    input  logic             rd_clk,
    input  logic             arst_n,
    input  logic [WIDTH-1:0] wr_data,
    input  logic             wr_en,
    output logic             full,
    output logic [WIDTH-1:0] rd_data,
    output logic             rd_valid,
    input  logic             rd_en
);

    localparam int AW     = $clog2(DEPTH);
    localparam int N_SYNC = `SYNC_STAGES;

    logic [WIDTH-1:0] mem [DEPTH];

    // write domain pointers
    logic [AW:0] wr_bin;
    logic [AW:0] wr_bin_next;
    logic [AW:0] wr_gray;
    fifo_ptr_t   wr_gray_next;
    logic        wr_push;

    // read domain pointers
    logic [AW:0] rd_bin;
    logic [AW:0] rd_bin_next;
    logic [AW:0] rd_gray;
    fifo_ptr_t   rd_gray_next;
    logic        rd_pop;
    logic        empty;

    // gray pointers seen from the other side
    logic [AW:0] rd_gray_sync [N_SYNC];
    logic [AW:0] wr_gray_sync [N_SYNC];

    assign wr_push     = wr_en && !full;
    assign wr_bin_next = wr_bin + {{AW{1'b0}}, wr_push};
    // zero-extended so the top gray bit matches this pointer width
    assign wr_gray_next = bin_to_gray(fifo_ptr_t'(wr_bin_next));

    always_ff @(posedge wr_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end else begin
            wr_bin  <= wr_bin_next;
            wr_gray <= wr_gray_next[AW:0];
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_push) begin
            mem[wr_bin[AW-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge wr_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < N_SYNC; i++) begin
                rd_gray_sync[i] <= '0;
            end
        end else begin
            rd_gray_sync[0] <= rd_gray;
            for (int i = 1; i < N_SYNC; i++) begin
                rd_gray_sync[i] <= rd_gray_sync[i-1];
            end
        end
    end

    // full when the write side is one lap ahead, top two gray bits flipped
    assign full = (wr_gray == {~rd_gray_sync[N_SYNC-1][AW:AW-1],
                               rd_gray_sync[N_SYNC-1][AW-2:0]});

    assign rd_pop       = rd_en && rd_valid;
    assign rd_bin_next  = rd_bin + {{AW{1'b0}}, rd_pop};
    assign rd_gray_next = bin_to_gray(fifo_ptr_t'(rd_bin_next));

    always_ff @(posedge rd_clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_bin  <= '0;
            rd_gray <= '0;
        end else begin
            rd_bin  <= rd_bin_next;
            rd_gray <= rd_gray_next[AW:0];
        end
    end

    always_ff @(posedge rd_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < N_SYNC; i++) begin
                wr_gray_sync[i] <= '0;
            end
        end else begin
            wr_gray_sync[0] <= wr_gray;
            for (int i = 1; i < N_SYNC; i++) begin
                wr_gray_sync[i] <= wr_gray_sync[i-1];
            end
        end
    end

    assign empty = (rd_gray == wr_gray_sync[N_SYNC-1]);

    // first word falls through, head of the queue is always on rd_data
    assign rd_valid = !empty;
    assign rd_data  = mem[rd_bin[AW-1:0]];

endmodule

//--- logic/cdc_pkg.sv
`include "ack_macros.svh"

package cdc_pkg;

    // address bits of the deepest FIFO plus the wrap bit
    localparam int PTR_W = $clog2(`ACK_FIFO_DEPTH) + 1;

    // sized for the largest FIFO, smaller ones use the low bits
    typedef logic [PTR_W-1:0] fifo_ptr_t;

    // binary to gray, only one bit changes per increment
    // callers must zero the bits above their own pointer width
    function automatic fifo_ptr_t bin_to_gray(input fifo_ptr_t bin);
        fifo_ptr_t gray;
        gray = bin ^ (bin >> 1);
        return gray;
    endfunction

endpackage

//--- logic/doneaddr_broadcast.sv
`include "ack_macros.svh"

module doneaddr_broadcast
    import ack_msg_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  done_addr_t              in_addr,
    input  logic                    in_valid,
    output logic                    in_rd,
    output done_addr_t              out_addr,
    output logic [`N_CONSUMERS-1:0] out_valid,
    input  logic [`N_CONSUMERS-1:0] out_ready
);

    localparam int N = `N_CONSUMERS;

    done_addr_t   hold_addr;
    logic [N-1:0] pending;
    logic [N-1:0] taken;
    logic         idle;

    // consumers that transfer on this edge
    assign taken = out_valid & out_ready;

    // holding register is free once nothing is left to deliver
    assign idle = ~|pending;

    // pull the next address only once every consumer has the current one
    assign in_rd = in_valid && idle;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= '0;
        end else if (in_rd) begin
            // every consumer owes a transfer for the new word
            pending <= '1;
        end else begin
            pending <= pending & ~taken;
        end
    end

    // the word being broadcast
    always_ff @(posedge clk) begin
        if (in_rd) begin
            hold_addr <= in_addr;
        end
    end

    // a consumer that already took the word sees valid low until the next
    // one is loaded, so a slow consumer only holds back the following word
    assign out_valid = pending;

    // all consumers see the same word, so one data bus is enough
    assign out_addr = hold_addr;

endmodule

//--- logic/flag_sync.sv
`include "ack_macros.svh"

module flag_sync (
    input  logic clk_a,
    input  logic clk_b,
    input  logic arst_n,
    input  logic flag_a,
    output logic flag_b
);

    localparam int N_SYNC = `SYNC_STAGES;

    logic              toggle_a;
    logic [N_SYNC-1:0] sync_b;
    logic              hist_b;

    // each flag becomes a level change, safe to sample slowly
    always_ff @(posedge clk_a or negedge arst_n) begin
        if (!arst_n) begin
            toggle_a <= 1'b0;
        end else if (flag_a) begin
            toggle_a <= ~toggle_a;
        end
    end

    always_ff @(posedge clk_b or negedge arst_n) begin
        if (!arst_n) begin
            sync_b <= '0;
            hist_b <= 1'b0;
        end else begin
            sync_b <= {sync_b[N_SYNC-2:0], toggle_a};
            hist_b <= sync_b[N_SYNC-1];
        end
    end

    // any change of the synced level is one pulse
    assign flag_b = sync_b[N_SYNC-1] ^ hist_b;

endmodule

//--- sim.f
+incdir+logic
logic/ack_msg_pkg.sv
logic/cdc_pkg.sv
logic/async_fifo.sv
logic/flag_sync.sv
logic/doneaddr_broadcast.sv
logic/ack_done_generator.sv
tests/ack_done_generator_tb.sv

//--- tests/ack_done_generator_tb.sv
`include "ack_macros.svh"

module ack_done_generator_tb
    import ack_msg_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_CONS = `N_CONSUMERS;
    localparam int PERIOD = 100;
    localparam int DEPTH  = `NACK_FIFO_DEPTH;

    logic aclk;
    logic memclk;
    logic arst_n;

    ack_word_t  s_ack_tdata;
    logic       s_ack_tvalid;
    logic       s_ack_tready;
    ack_word_t  s_nack_tdata;
    logic       s_nack_tvalid;
    logic       s_nack_tready;
    nack_word_t m_nack_tdata;
    logic       m_nack_tvalid;
    logic       m_nack_tready;
    logic       allow;

    // consumer order follows the RTL, header stream on bit 4
    wire  [N_CONS-1:0]         out_valid;
    wire  [`DONE_ADDR_W-1:0]   out_data [N_CONS];
    logic [N_CONS-1:0]         out_ready;
    string cons_name [N_CONS] = '{"m_t3addr_tdata", "m_t2addr_tdata", "m_t1addr_tdata",
                                  "m_t0addr_tdata", "m_hdraddr_tdata"};

    int err_count;
    int err_mark;
    int tests_ok;
    int tests_bad;
    int got_idx [N_CONS];
    int nack_got;
    int nack_sent;
    int allow_count;
    int exp_allow;

    done_addr_t  exp_addr [$];
    nack_word_t  exp_nack [$];
    logic [31:0] rec_kind [$];
    ack_word_t   rec_word [$];
    logic [63:0] rec_exp [$];

    logic              loaded;
    logic              throttle;
    logic [N_CONS-1:0] hold_low;
    logic              nack_hold;
    logic [15:0]       lfsr;

    ack_done_generator dut0 (
        .aclk             (aclk),
        .arst_n           (arst_n),
        .s_ack_tdata      (s_ack_tdata),
        .s_ack_tvalid     (s_ack_tvalid),
        .s_ack_tready     (s_ack_tready),
        .s_nack_tdata     (s_nack_tdata),
        .s_nack_tvalid    (s_nack_tvalid),
        .s_nack_tready    (s_nack_tready),
        .memclk           (memclk),
        .m_nack_tdata     (m_nack_tdata),
        .m_nack_tvalid    (m_nack_tvalid),
        .m_nack_tready    (m_nack_tready),
        .allow            (allow),
        .m_hdraddr_tdata  (out_data[4]),
        .m_hdraddr_tvalid (out_valid[4]),
        .m_hdraddr_tready (out_ready[4]),
        .m_t0addr_tdata   (out_data[3]),
        .m_t0addr_tvalid  (out_valid[3]),
        .m_t0addr_tready  (out_ready[3]),
        .m_t1addr_tdata   (out_data[2]),
        .m_t1addr_tvalid  (out_valid[2]),
        .m_t1addr_tready  (out_ready[2]),
        .m_t2addr_tdata   (out_data[1]),
        .m_t2addr_tvalid  (out_valid[1]),
        .m_t2addr_tready  (out_ready[1]),
        .m_t3addr_tdata   (out_data[0]),
        .m_t3addr_tvalid  (out_valid[0]),
        .m_t3addr_tready  (out_ready[0])
    );

    initial begin
        aclk = 1'b0;
        forever #(PERIOD / 2) aclk = ~aclk;
    end

    // same period, shifted so the edges never line up
    initial begin
        memclk = 1'b0;
        #37;
        forever #(PERIOD / 2) memclk = ~memclk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (10) @(posedge aclk);
        arst_n <= 1'b1;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // done address sits in bits 31 down to 20 of an ack
    function automatic done_addr_t ack_addr(input ack_word_t w);
        return w[31:20];
    endfunction

    // nack keeps bit 46 on top of bits 42 down to 0
    function automatic nack_word_t nack_keep(input ack_word_t w);
        return {w[46], w[42:0]};
    endfunction

    function automatic ack_word_t fill_word(input int i);
        return {i[15:0] ^ 16'h3c3c, ~i[15:0], i[15:0]};
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %0h expected %0h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic end_test(input string name);
        if (err_count == err_mark) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, err_count - err_mark);
        end
        err_mark = err_count;
    endtask

    task automatic read_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] kind;
        ack_word_t   word;
        logic [63:0] expv;
        fd = $fopen("tests/ack_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file tests/ack_input.txt");
            err_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 3 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %h %h", kind, word, expv);
            if (n != 3) begin
                $display("malformed line in vector file: %s", line);
                err_count++;
                continue;
            end
            rec_kind.push_back(kind);
            rec_word.push_back(word);
            rec_exp.push_back(expv);
        end
        $fclose(fd);
    endtask

    // called just after a rising aclk edge
    task automatic send_ack(input ack_word_t w);
        s_ack_tdata  <= w;
        s_ack_tvalid <= 1'b1;
        do @(posedge aclk); while (!s_ack_tready);
        exp_addr.push_back(ack_addr(w));
        if (w[47]) begin
            exp_allow++;
        end
        s_ack_tvalid <= 1'b0;
        // keeps allow requests at least 3 aclk cycles apart
        repeat (3) @(posedge aclk);
    endtask

    task automatic send_nack(input ack_word_t w, input int gap);
        s_nack_tdata  <= w;
        s_nack_tvalid <= 1'b1;
        do @(posedge aclk); while (!s_nack_tready);
        exp_nack.push_back(nack_keep(w));
        nack_sent++;
        s_nack_tvalid <= 1'b0;
        repeat (gap) @(posedge aclk);
    endtask

    task automatic wait_delivered(input int addr_target, input int nack_target,
                                  input logic [N_CONS-1:0] mask);
        int   cyc;
        logic done;
        cyc  = 0;
        done = 1'b0;
        while (!done && cyc < 4 * DEPTH) begin
            @(negedge memclk);
            cyc++;
            done = (nack_got >= nack_target);
            for (int c = 0; c < N_CONS; c++) begin
                if (mask[c] && got_idx[c] < addr_target) begin
                    done = 1'b0;
                end
            end
        end
        if (!done) begin
            $display("outputs did not deliver all expected words within %0d cycles", cyc);
            err_count++;
        end
    endtask

    // consumer ready, random or forced, one LFSR step per random bit
    always @(posedge memclk) begin
        for (int c = 0; c < N_CONS; c++) begin
            if (hold_low[c]) begin
                out_ready[c] <= 1'b0;
            end else if (throttle) begin
                lfsr = lfsr_step(lfsr);
                out_ready[c] <= lfsr[0];
            end else begin
                out_ready[c] <= 1'b1;
            end
        end
        if (nack_hold) begin
            m_nack_tready <= 1'b0;
        end else begin
            lfsr = lfsr_step(lfsr);
            m_nack_tready <= lfsr[0];
        end
    end

    // output monitor, sees pre-edge values of both valid and ready
    always @(posedge memclk) begin
        if (allow) begin
            allow_count++;
        end
        for (int c = 0; c < N_CONS; c++) begin
            if (out_valid[c] && out_ready[c]) begin
                if (got_idx[c] < exp_addr.size()) begin
                    check_value(cons_name[c], out_data[c], exp_addr[got_idx[c]]);
                end else begin
                    $display("%s delivered an address that was never sent", cons_name[c]);
                    err_count++;
                end
                got_idx[c]++;
            end
        end
        if (m_nack_tvalid && m_nack_tready) begin
            if (exp_nack.size() > 0) begin
                check_value("m_nack_tdata", m_nack_tdata, exp_nack.pop_front());
            end else begin
                $display("m_nack_tdata delivered a word that was never sent");
                err_count++;
            end
            nack_got++;
        end
    end

    initial begin
        wait (loaded);
        #((rec_word.size() * 40 + 4 * DEPTH + 200) * PERIOD);
        $display("timeout: the run did not finish within its time limit");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int base;
        int accepted;
        int cyc;
        s_ack_tdata   = '0;
        s_ack_tvalid  = 1'b0;
        s_nack_tdata  = '0;
        s_nack_tvalid = 1'b0;
        m_nack_tready = 1'b0;
        out_ready     = '0;
        throttle      = 1'b0;
        hold_low      = '0;
        nack_hold     = 1'b0;
        lfsr          = 16'd68;
        err_count     = 0;
        err_mark      = 0;
        tests_ok      = 0;
        tests_bad     = 0;
        nack_got      = 0;
        nack_sent     = 0;
        allow_count   = 0;
        exp_allow     = 0;
        for (int c = 0; c < N_CONS; c++) begin
            got_idx[c] = 0;
        end
        loaded = 1'b0;

        read_vectors();
        loaded = 1'b1;
        if (rec_word.size() == 0) begin
            $display("vector file holds no records");
            err_count++;
        end
        for (int i = 0; i < rec_word.size(); i++) begin
            if (rec_kind[i] == "ack") begin
                check_value("file done address", rec_exp[i], ack_addr(rec_word[i]));
            end else if (rec_kind[i] == "nack") begin
                check_value("file nack word", rec_exp[i], nack_keep(rec_word[i]));
            end else begin
                $display("unknown record kind on vector %0d", i);
                err_count++;
            end
        end
        end_test("vector file");

        repeat (5) @(negedge memclk);
        check_value("m_*addr_tvalid in reset", out_valid, '0);
        check_value("m_nack_tvalid in reset", m_nack_tvalid, 1'b0);
        check_value("allow in reset", allow, 1'b0);
        wait (arst_n);
        repeat (3) @(negedge memclk);
        check_value("m_*addr_tvalid after reset", out_valid, '0);
        check_value("m_nack_tvalid after reset", m_nack_tvalid, 1'b0);
        check_value("allow after reset", allow, 1'b0);
        check_value("s_ack_tready", s_ack_tready, 1'b1);
        check_value("s_nack_tready", s_nack_tready, 1'b1);
        end_test("reset");

        throttle = 1'b1;
        @(posedge aclk);
        for (int i = 0; i < rec_word.size(); i++) begin
            if (rec_kind[i] == "ack") begin
                send_ack(rec_word[i]);
            end
        end
        wait_delivered(exp_addr.size(), nack_sent, '1);
        end_test("ack ordering and broadcast");

        // stall t2 only, the rest take every word at once
        base     = exp_addr.size();
        throttle = 1'b0;
        hold_low = 5'b00010;
        @(posedge aclk);
        for (int i = 0; i < rec_word.size(); i++) begin
            if (rec_kind[i] == "ack") begin
                send_ack(rec_word[i]);
            end
        end
        wait_delivered(base + 1, nack_sent, ~hold_low);
        repeat (20) @(negedge memclk);
        for (int c = 0; c < N_CONS; c++) begin
            check_value({cons_name[c], " transfers"}, got_idx[c], (c == 1) ? base : base + 1);
        end
        check_value("m_*addr_tvalid while t2 stalls", out_valid, 5'b00010);
        hold_low = '0;
        throttle = 1'b1;
        wait_delivered(exp_addr.size(), nack_sent, '1);
        end_test("back-pressure isolation");

        @(posedge aclk);
        for (int i = 0; i < rec_word.size(); i++) begin
            if (rec_kind[i] == "nack") begin
                send_nack(rec_word[i], 1);
            end
        end
        wait_delivered(exp_addr.size(), nack_sent, '1);
        end_test("nack path");

        repeat (10) @(negedge memclk);
        check_value("allow pulses", allow_count, exp_allow);
        end_test("allow flag");

        // fill the nack FIFO with the reader stopped
        nack_hold = 1'b1;
        @(posedge aclk);
        accepted = 0;
        cyc      = 0;
        s_nack_tdata  <= fill_word(0);
        s_nack_tvalid <= 1'b1;
        while (accepted < DEPTH && cyc < 2 * DEPTH) begin
            @(posedge aclk);
            cyc++;
            if (s_nack_tready) begin
                exp_nack.push_back(nack_keep(fill_word(accepted)));
                nack_sent++;
                accepted++;
                s_nack_tdata <= fill_word(accepted);
            end
        end
        check_value("nacks accepted before full", accepted, DEPTH);
        repeat (8) begin
            @(posedge aclk);
            if (s_nack_tready) begin
                $display("s_nack_tready rose while the nack FIFO should be full");
                err_count++;
            end
        end
        nack_hold = 1'b0;
        send_nack(fill_word(accepted), 0);
        wait_delivered(exp_addr.size(), nack_sent, '1);
        check_value("nack words left", exp_nack.size(), 0);
        end_test("full nack FIFO");

        $display("summary: %0d tests ok, %0d tests failed, %0d errors",
                 tests_ok, tests_bad, err_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tests/ack_input.txt
# kind word expected
# ack: expected is bits 31:20, nack: expected is bit 46 over bits 42:0
ack 800012300000 123
nack 400000000001 80000000001
ack 000045600abc 456
ack 8fff789fffff 789
nack 3fffffffffff 7ffffffffff
ack 1234abcdef01 abc
nack b812345678ab 012345678ab
ack c000fff00000 fff
ack 7ffff00fffff f00
nack 6a0000c0ffee a0000c0ffee
ack 000000100000 001
nack f5dead00beef ddead00beef
ack 9123a5e78abc a5e
nack 0c0102030405 40102030405
ack 0000dea00000 dea
nack 4f0000000000 f0000000000
ack 800f3c50ffff 3c5
nack 112233445566 12233445566
ack ffffffffffff fff
ack 555555555555 555
